// File: ao_bus_pkg.sv
// Bus widths shared by the always-on subsystem
// All accesses are full 32-bit words and byte enables are not carried
package ao_bus_pkg;

  // OBI and register bus data word
  localparam int unsigned DATA_W = 32;

  // OBI and register bus byte address
  localparam int unsigned ADDR_W = 32;

  // Fast interrupt lines handled by fast_intr_ctrl
  localparam int unsigned NUM_FAST_INTR = 15;

  // Pins driven and sampled by gpio_ao
  localparam int unsigned NUM_GPIO = 8;

endpackage

// File: ao_map_pkg.sv
// Address map of the always-on block
// Peripheral index sits in bits 15:12, register offset in bits 11:0
package ao_map_pkg;

  localparam int unsigned REGION_W     = 16;
  localparam int unsigned PERIPH_IDX_W = 4;
  localparam int unsigned REG_OFF_W    = 12;

  // Upper address bits of the always-on region
  localparam logic [REGION_W-1:0] AO_REGION = 16'h2000;

  localparam logic [PERIPH_IDX_W-1:0] NUM_AO_PERIPH = 4'd3;

  localparam logic [PERIPH_IDX_W-1:0] SOC_CTRL_IDX  = 4'd0;
  localparam logic [PERIPH_IDX_W-1:0] FAST_INTR_IDX = 4'd1;
  localparam logic [PERIPH_IDX_W-1:0] GPIO_IDX      = 4'd2;

  // soc_ctrl
  localparam logic [REG_OFF_W-1:0] EXIT_VALID_OFF  = 12'h000;
  localparam logic [REG_OFF_W-1:0] EXIT_VALUE_OFF  = 12'h004;
  localparam logic [REG_OFF_W-1:0] BOOT_SELECT_OFF = 12'h008;

  // fast_intr_ctrl
  localparam logic [REG_OFF_W-1:0] FI_PENDING_OFF = 12'h000;
  localparam logic [REG_OFF_W-1:0] FI_ENABLE_OFF  = 12'h004;

  // gpio_ao
  localparam logic [REG_OFF_W-1:0] GPIO_DIR_OFF         = 12'h000;
  localparam logic [REG_OFF_W-1:0] GPIO_OUT_OFF         = 12'h004;
  localparam logic [REG_OFF_W-1:0] GPIO_IN_OFF          = 12'h008;
  localparam logic [REG_OFF_W-1:0] GPIO_INTR_EN_OFF     = 12'h00C;
  localparam logic [REG_OFF_W-1:0] GPIO_INTR_STATUS_OFF = 12'h010;

  // Flat address word or its decoded fields
  typedef union packed {
    logic [ao_bus_pkg::ADDR_W-1:0] word;
    struct packed {
      logic [REGION_W-1:0]     region;
      logic [PERIPH_IDX_W-1:0] periph_idx;
      logic [REG_OFF_W-1:0]    reg_off;
    } fields;
  } ao_addr_u;

endpackage

// File: obi_to_reg.sv
// OBI slave to register bus bridge that grants every request at once
// The response comes one cycle after the grant and never stalls
`timescale 1ns/1ps

module obi_to_reg (
  input  logic                          clk_i,
  input  logic                          arst_n_i,

  input  logic                          obi_req_i,
  input  logic                          obi_we_i,
  input  logic [ao_bus_pkg::ADDR_W-1:0] obi_addr_i,
  input  logic [ao_bus_pkg::DATA_W-1:0] obi_wdata_i,
  output logic                          obi_gnt_o,
  output logic                          obi_rvalid_o,
  output logic [ao_bus_pkg::DATA_W-1:0] obi_rdata_o,

  output logic                          reg_valid_o,
  output logic                          reg_write_o,
  output logic [ao_bus_pkg::ADDR_W-1:0] reg_addr_o,
  output logic [ao_bus_pkg::DATA_W-1:0] reg_wdata_o,
  input  logic [ao_bus_pkg::DATA_W-1:0] reg_rdata_i
);

  logic                          rvalid_q;
  logic [ao_bus_pkg::DATA_W-1:0] rdata_q;

  // Peripherals answer in the same cycle, so there is never a reason to stall
  assign obi_gnt_o = obi_req_i;

  assign reg_valid_o = obi_req_i;
  assign reg_write_o = obi_we_i;
  assign reg_addr_o  = obi_addr_i;
  assign reg_wdata_o = obi_wdata_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= obi_req_i;
    end
  end

  // Writes return zero data
  always_ff @(posedge clk_i) begin
    if (obi_req_i) begin
      rdata_q <= obi_we_i ? '0 : reg_rdata_i;
    end
  end

  assign obi_rvalid_o = rvalid_q;
  assign obi_rdata_o  = rdata_q;

endmodule

// File: ao_reg_demux.sv
// Routes a register strobe to one always-on peripheral
// Unmapped addresses select nothing and read back zero
`timescale 1ns/1ps

module ao_reg_demux (
  input  logic                             reg_valid_i,
  input  logic [ao_bus_pkg::ADDR_W-1:0]    reg_addr_i,
  output logic [ao_map_pkg::REG_OFF_W-1:0] reg_off_o,
  output logic [ao_bus_pkg::DATA_W-1:0]    reg_rdata_o,

  output logic                             soc_sel_o,
  output logic                             fi_sel_o,
  output logic                             gpio_sel_o,

  input  logic [ao_bus_pkg::DATA_W-1:0]    soc_rdata_i,
  input  logic [ao_bus_pkg::DATA_W-1:0]    fi_rdata_i,
  input  logic [ao_bus_pkg::DATA_W-1:0]    gpio_rdata_i
);

  ao_map_pkg::ao_addr_u addr_u;
  logic                 hit;

  assign addr_u.word = reg_addr_i;

  assign hit = (addr_u.fields.region == ao_map_pkg::AO_REGION) &&
               (addr_u.fields.periph_idx < ao_map_pkg::NUM_AO_PERIPH);

  assign reg_off_o = addr_u.fields.reg_off;

  always_comb begin
    soc_sel_o  = 1'b0;
    fi_sel_o   = 1'b0;
    gpio_sel_o = 1'b0;
    reg_rdata_o = '0;
    if (hit) begin
      case (addr_u.fields.periph_idx)
        ao_map_pkg::SOC_CTRL_IDX: begin
          soc_sel_o   = reg_valid_i;
          reg_rdata_o = soc_rdata_i;
        end
        ao_map_pkg::FAST_INTR_IDX: begin
          fi_sel_o    = reg_valid_i;
          reg_rdata_o = fi_rdata_i;
        end
        ao_map_pkg::GPIO_IDX: begin
          gpio_sel_o  = reg_valid_i;
          reg_rdata_o = gpio_rdata_i;
        end
        default: begin
          reg_rdata_o = '0;
        end
      endcase
    end
  end

endmodule

// File: soc_ctrl.sv
// Exit status registers and boot select readout
// BOOT_SELECT is read only, writes to it are dropped
`timescale 1ns/1ps

module soc_ctrl (
  input  logic                             clk_i,
  input  logic                             arst_n_i,

  input  logic                             sel_i,
  input  logic                             write_i,
  input  logic [ao_map_pkg::REG_OFF_W-1:0] reg_off_i,
  input  logic [ao_bus_pkg::DATA_W-1:0]    wdata_i,
  output logic [ao_bus_pkg::DATA_W-1:0]    rdata_o,

  input  logic                             boot_select_i,
  output logic                             exit_valid_o,
  output logic [ao_bus_pkg::DATA_W-1:0]    exit_value_o
);

  logic                          exit_valid_q;
  logic [ao_bus_pkg::DATA_W-1:0] exit_value_q;
  logic                          wr_en;

  assign wr_en = sel_i && write_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (wr_en) begin
      if (reg_off_i == ao_map_pkg::EXIT_VALID_OFF) begin
        exit_valid_q <= wdata_i[0];
      end
      if (reg_off_i == ao_map_pkg::EXIT_VALUE_OFF) begin
        exit_value_q <= wdata_i;
      end
    end
  end

  always_comb begin
    case (reg_off_i)
      ao_map_pkg::EXIT_VALID_OFF:  rdata_o = {{(ao_bus_pkg::DATA_W-1){1'b0}}, exit_valid_q};
      ao_map_pkg::EXIT_VALUE_OFF:  rdata_o = exit_value_q;
      ao_map_pkg::BOOT_SELECT_OFF: rdata_o = {{(ao_bus_pkg::DATA_W-1){1'b0}}, boot_select_i};
      default:                     rdata_o = '0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

// File: fast_intr_ctrl.sv
// Level sensitive latch of the fast interrupt lines with a mask
// A line still high at the clearing write keeps its pending bit set
`timescale 1ns/1ps

module fast_intr_ctrl (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,

  input  logic                                 sel_i,
  input  logic                                 write_i,
  input  logic [ao_map_pkg::REG_OFF_W-1:0]     reg_off_i,
  input  logic [ao_bus_pkg::DATA_W-1:0]        wdata_i,
  output logic [ao_bus_pkg::DATA_W-1:0]        rdata_o,

  input  logic [ao_bus_pkg::NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [ao_bus_pkg::NUM_FAST_INTR-1:0] fast_intr_o
);

  localparam int unsigned PAD_W = ao_bus_pkg::DATA_W - ao_bus_pkg::NUM_FAST_INTR;

  logic [ao_bus_pkg::NUM_FAST_INTR-1:0] pending_q;
  logic [ao_bus_pkg::NUM_FAST_INTR-1:0] enable_q;
  logic [ao_bus_pkg::NUM_FAST_INTR-1:0] clr;
  logic                                 wr_en;

  assign wr_en = sel_i && write_i;
  assign clr   = (wr_en && reg_off_i == ao_map_pkg::FI_PENDING_OFF) ?
                 wdata_i[ao_bus_pkg::NUM_FAST_INTR-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // Set has priority over clear
      pending_q <= (pending_q & ~clr) | fast_intr_i;
      if (wr_en && reg_off_i == ao_map_pkg::FI_ENABLE_OFF) begin
        enable_q <= wdata_i[ao_bus_pkg::NUM_FAST_INTR-1:0];
      end
    end
  end

  always_comb begin
    case (reg_off_i)
      ao_map_pkg::FI_PENDING_OFF: rdata_o = {{PAD_W{1'b0}}, pending_q};
      ao_map_pkg::FI_ENABLE_OFF:  rdata_o = {{PAD_W{1'b0}}, enable_q};
      default:                    rdata_o = '0;
    endcase
  end

  assign fast_intr_o = pending_q & enable_q;

endmodule

// File: gpio_ao.sv
// Always-on GPIO with two flop input sync and rising edge interrupts
// gpio_o is not gated by direction since the pad applies gpio_en_o
`timescale 1ns/1ps

module gpio_ao (
  input  logic                             clk_i,
  input  logic                             arst_n_i,

  input  logic                             sel_i,
  input  logic                             write_i,
  input  logic [ao_map_pkg::REG_OFF_W-1:0] reg_off_i,
  input  logic [ao_bus_pkg::DATA_W-1:0]    wdata_i,
  output logic [ao_bus_pkg::DATA_W-1:0]    rdata_o,

  input  logic [ao_bus_pkg::NUM_GPIO-1:0]  gpio_i,
  output logic [ao_bus_pkg::NUM_GPIO-1:0]  gpio_o,
  output logic [ao_bus_pkg::NUM_GPIO-1:0]  gpio_en_o,
  output logic [ao_bus_pkg::NUM_GPIO-1:0]  intr_gpio_o
);

  localparam int unsigned PAD_W = ao_bus_pkg::DATA_W - ao_bus_pkg::NUM_GPIO;

  logic [ao_bus_pkg::NUM_GPIO-1:0] dir_q;
  logic [ao_bus_pkg::NUM_GPIO-1:0] out_q;
  logic [ao_bus_pkg::NUM_GPIO-1:0] intr_en_q;
  logic [ao_bus_pkg::NUM_GPIO-1:0] status_q;
  logic [ao_bus_pkg::NUM_GPIO-1:0] sync1_q;
  logic [ao_bus_pkg::NUM_GPIO-1:0] sync2_q;
  logic [ao_bus_pkg::NUM_GPIO-1:0] prev_q;
  logic [ao_bus_pkg::NUM_GPIO-1:0] rise;
  logic [ao_bus_pkg::NUM_GPIO-1:0] clr;
  logic                            wr_en;

  assign wr_en = sel_i && write_i;
  assign rise  = sync2_q & ~prev_q;
  assign clr   = (wr_en && reg_off_i == ao_map_pkg::GPIO_INTR_STATUS_OFF) ?
                 wdata_i[ao_bus_pkg::NUM_GPIO-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync1_q  <= '0;
      sync2_q  <= '0;
      prev_q   <= '0;
      status_q <= '0;
    end else begin
      sync1_q  <= gpio_i;
      sync2_q  <= sync1_q;
      prev_q   <= sync2_q;
      status_q <= (status_q & ~clr) | rise;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dir_q     <= '0;
      out_q     <= '0;
      intr_en_q <= '0;
    end else if (wr_en) begin
      case (reg_off_i)
        ao_map_pkg::GPIO_DIR_OFF:     dir_q     <= wdata_i[ao_bus_pkg::NUM_GPIO-1:0];
        ao_map_pkg::GPIO_OUT_OFF:     out_q     <= wdata_i[ao_bus_pkg::NUM_GPIO-1:0];
        ao_map_pkg::GPIO_INTR_EN_OFF: intr_en_q <= wdata_i[ao_bus_pkg::NUM_GPIO-1:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (reg_off_i)
      ao_map_pkg::GPIO_DIR_OFF:         rdata_o = {{PAD_W{1'b0}}, dir_q};
      ao_map_pkg::GPIO_OUT_OFF:         rdata_o = {{PAD_W{1'b0}}, out_q};
      ao_map_pkg::GPIO_IN_OFF:          rdata_o = {{PAD_W{1'b0}}, sync2_q};
      ao_map_pkg::GPIO_INTR_EN_OFF:     rdata_o = {{PAD_W{1'b0}}, intr_en_q};
      ao_map_pkg::GPIO_INTR_STATUS_OFF: rdata_o = {{PAD_W{1'b0}}, status_q};
      default:                          rdata_o = '0;
    endcase
  end

  assign gpio_o      = out_q;
  assign gpio_en_o   = dir_q;
  assign intr_gpio_o = status_q & intr_en_q;

endmodule

// File: ao_peripheral_subsystem.sv
// Always-on peripheral subsystem behind a single OBI slave port
// Holds soc_ctrl, fast_intr_ctrl and gpio_ao
// The OBI response carries no error field
`timescale 1ns/1ps

module ao_peripheral_subsystem (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,

  input  logic                                 obi_req_i,
  input  logic                                 obi_we_i,
  input  logic [ao_bus_pkg::ADDR_W-1:0]        obi_addr_i,
  input  logic [ao_bus_pkg::DATA_W-1:0]        obi_wdata_i,
  output logic                                 obi_gnt_o,
  output logic                                 obi_rvalid_o,
  output logic [ao_bus_pkg::DATA_W-1:0]        obi_rdata_o,

  // SoC control
  input  logic                                 boot_select_i,
  output logic                                 exit_valid_o,
  output logic [ao_bus_pkg::DATA_W-1:0]        exit_value_o,

  // Fast interrupts
  input  logic [ao_bus_pkg::NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [ao_bus_pkg::NUM_FAST_INTR-1:0] fast_intr_o,

  // GPIO pins
  input  logic [ao_bus_pkg::NUM_GPIO-1:0]      gpio_i,
  output logic [ao_bus_pkg::NUM_GPIO-1:0]      gpio_o,
  output logic [ao_bus_pkg::NUM_GPIO-1:0]      gpio_en_o,
  output logic [ao_bus_pkg::NUM_GPIO-1:0]      intr_gpio_o
);

  logic                             reg_valid;
  logic                             reg_write;
  logic [ao_bus_pkg::ADDR_W-1:0]    reg_addr;
  logic [ao_bus_pkg::DATA_W-1:0]    reg_wdata;
  logic [ao_bus_pkg::DATA_W-1:0]    reg_rdata;
  logic [ao_map_pkg::REG_OFF_W-1:0] reg_off;

  logic                             soc_sel;
  logic                             fi_sel;
  logic                             gpio_sel;
  logic [ao_bus_pkg::DATA_W-1:0]    soc_rdata;
  logic [ao_bus_pkg::DATA_W-1:0]    fi_rdata;
  logic [ao_bus_pkg::DATA_W-1:0]    gpio_rdata;

  obi_to_reg obi_to_reg_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .obi_req_i    (obi_req_i),
    .obi_we_i     (obi_we_i),
    .obi_addr_i   (obi_addr_i),
    .obi_wdata_i  (obi_wdata_i),
    .obi_gnt_o    (obi_gnt_o),
    .obi_rvalid_o (obi_rvalid_o),
    .obi_rdata_o  (obi_rdata_o),
    .reg_valid_o  (reg_valid),
    .reg_write_o  (reg_write),
    .reg_addr_o   (reg_addr),
    .reg_wdata_o  (reg_wdata),
    .reg_rdata_i  (reg_rdata)
  );

  ao_reg_demux ao_reg_demux_i (
    .reg_valid_i  (reg_valid),
    .reg_addr_i   (reg_addr),
    .reg_off_o    (reg_off),
    .reg_rdata_o  (reg_rdata),
    .soc_sel_o    (soc_sel),
    .fi_sel_o     (fi_sel),
    .gpio_sel_o   (gpio_sel),
    .soc_rdata_i  (soc_rdata),
    .fi_rdata_i   (fi_rdata),
    .gpio_rdata_i (gpio_rdata)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .sel_i         (soc_sel),
    .write_i       (reg_write),
    .reg_off_i     (reg_off),
    .wdata_i       (reg_wdata),
    .rdata_o       (soc_rdata),
    .boot_select_i (boot_select_i),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o)
  );

  fast_intr_ctrl fast_intr_ctrl_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .sel_i       (fi_sel),
    .write_i     (reg_write),
    .reg_off_i   (reg_off),
    .wdata_i     (reg_wdata),
    .rdata_o     (fi_rdata),
    .fast_intr_i (fast_intr_i),
    .fast_intr_o (fast_intr_o)
  );

  gpio_ao gpio_ao_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .sel_i       (gpio_sel),
    .write_i     (reg_write),
    .reg_off_i   (reg_off),
    .wdata_i     (reg_wdata),
    .rdata_o     (gpio_rdata),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_en_o   (gpio_en_o),
    .intr_gpio_o (intr_gpio_o)
  );

endmodule

// File: tb_ao_peripheral_subsystem.sv
// Testbench for the always-on peripheral subsystem
// Expected read data comes from a register model that follows the address map
// Pin inputs are held long enough for the two flop sync before they are read
`timescale 1ns/1ps

module tb_ao_peripheral_subsystem;

  localparam int          TIMEOUT          = 20;
  localparam logic [31:0] EXIT_VALID       = 32'h2000_0000;
  localparam logic [31:0] EXIT_VALUE       = 32'h2000_0004;
  localparam logic [31:0] BOOT_SELECT      = 32'h2000_0008;
  localparam logic [31:0] FI_PENDING       = 32'h2000_1000;
  localparam logic [31:0] FI_ENABLE        = 32'h2000_1004;
  localparam logic [31:0] GPIO_DIR         = 32'h2000_2000;
  localparam logic [31:0] GPIO_OUT         = 32'h2000_2004;
  localparam logic [31:0] GPIO_IN          = 32'h2000_2008;
  localparam logic [31:0] GPIO_INTR_EN     = 32'h2000_200C;
  localparam logic [31:0] GPIO_INTR_STATUS = 32'h2000_2010;
  localparam logic [31:0] REG_LIST [10]    = '{EXIT_VALID, EXIT_VALUE, BOOT_SELECT,
                                               FI_PENDING, FI_ENABLE, GPIO_DIR, GPIO_OUT,
                                               GPIO_IN, GPIO_INTR_EN, GPIO_INTR_STATUS};

  logic        clk;
  logic        arst_n;
  logic        obi_req;
  logic        obi_we;
  logic [31:0] obi_addr;
  logic [31:0] obi_wdata;
  logic        obi_gnt;
  logic        obi_rvalid;
  logic [31:0] obi_rdata;
  logic        boot_select;
  logic        exit_valid;
  logic [31:0] exit_value;
  logic [14:0] fast_intr_in;
  logic [14:0] fast_intr_out;
  logic [7:0]  gpio_in;
  logic [7:0]  gpio_out;
  logic [7:0]  gpio_en;
  logic [7:0]  intr_gpio;

  // Register model
  logic        m_exit_valid = 1'b0;
  logic [31:0] m_exit_value = '0;
  logic [14:0] m_fi_pending = '0;
  logic [14:0] m_fi_enable  = '0;
  logic [7:0]  m_dir        = '0;
  logic [7:0]  m_out        = '0;
  logic [7:0]  m_in         = '0;
  logic [7:0]  m_intr_en    = '0;
  logic [7:0]  m_status     = '0;

  logic [31:0] expect_q [$];
  logic [31:0] rnd;
  logic        aborted    = 1'b0;
  int          checks     = 0;
  int          err_cnt    = 0;
  int          fail_cnt   = 0;
  int          grant_cnt  = 0;
  int          rvalid_cnt = 0;

  ao_peripheral_subsystem i_dut (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .obi_req_i     (obi_req),
    .obi_we_i      (obi_we),
    .obi_addr_i    (obi_addr),
    .obi_wdata_i   (obi_wdata),
    .obi_gnt_o     (obi_gnt),
    .obi_rvalid_o  (obi_rvalid),
    .obi_rdata_o   (obi_rdata),
    .boot_select_i (boot_select),
    .exit_valid_o  (exit_valid),
    .exit_value_o  (exit_value),
    .fast_intr_i   (fast_intr_in),
    .fast_intr_o   (fast_intr_out),
    .gpio_i        (gpio_in),
    .gpio_o        (gpio_out),
    .gpio_en_o     (gpio_en),
    .intr_gpio_o   (intr_gpio)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // Expected read data of one address
  // Anything outside the map reads as zero
  function automatic logic [31:0] ref_read(input logic [31:0] addr);
    logic [31:0] rd;
    rd = '0;
    if (addr[31:16] == 16'h2000) begin
      case (addr[15:0])
        16'h0000: rd = {31'b0, m_exit_valid};
        16'h0004: rd = m_exit_value;
        16'h0008: rd = {31'b0, boot_select};
        16'h1000: rd = {17'b0, m_fi_pending};
        16'h1004: rd = {17'b0, m_fi_enable};
        16'h2000: rd = {24'b0, m_dir};
        16'h2004: rd = {24'b0, m_out};
        16'h2008: rd = {24'b0, m_in};
        16'h200C: rd = {24'b0, m_intr_en};
        16'h2010: rd = {24'b0, m_status};
        default:  rd = '0;
      endcase
    end
    return rd;
  endfunction

  // Write 1 clears pending, but a line still high sets it again
  function automatic void model_write(input logic [31:0] addr, input logic [31:0] data);
    if (addr[31:16] == 16'h2000) begin
      case (addr[15:0])
        16'h0000: m_exit_valid = data[0];
        16'h0004: m_exit_value = data;
        16'h1000: m_fi_pending = (m_fi_pending & ~data[14:0]) | fast_intr_in;
        16'h1004: m_fi_enable  = data[14:0];
        16'h2000: m_dir        = data[7:0];
        16'h2004: m_out        = data[7:0];
        16'h200C: m_intr_en    = data[7:0];
        16'h2010: m_status     = m_status & ~data[7:0];
        default: ;
      endcase
    end
  endfunction

  function automatic void record_grant(input logic we, input logic [31:0] addr,
                                       input logic [31:0] data);
    grant_cnt++;
    expect_q.push_back(we ? 32'h0 : ref_read(addr));
    if (we) begin
      model_write(addr, data);
    end
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (!aborted) begin
      checks++;
      if (got !== exp) begin
        $display("error at time %0t: %s is %h, expected %h", $time, what, got, exp);
        err_cnt++;
      end
    end
  endtask

  task automatic check_outputs();
    check("exit_valid_o", {31'b0, exit_valid}, {31'b0, m_exit_valid});
    check("exit_value_o", exit_value, m_exit_value);
    check("fast_intr_o", {17'b0, fast_intr_out}, {17'b0, m_fi_pending & m_fi_enable});
    check("gpio_o", {24'b0, gpio_out}, {24'b0, m_out});
    check("gpio_en_o", {24'b0, gpio_en}, {24'b0, m_dir});
    check("intr_gpio_o", {24'b0, intr_gpio}, {24'b0, m_status & m_intr_en});
  endtask

  task automatic wait_grant(input logic [31:0] addr);
    int n;
    n = 0;
    @(posedge clk);
    while (!obi_gnt && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (!obi_gnt) begin
      $display("Timeout: the request to address %h was never granted", addr);
      fail_cnt++;
      aborted = 1'b1;
    end
  endtask

  // The response is due in the cycle right after the grant
  task automatic wait_rvalid();
    int n;
    n = 0;
    if (!aborted) begin
      @(negedge clk);
      while (!obi_rvalid && n < TIMEOUT) begin
        @(negedge clk);
        n++;
      end
      if (!obi_rvalid) begin
        $display("Timeout: no response arrived after a granted request");
        fail_cnt++;
        aborted = 1'b1;
      end else begin
        check("cycles of rvalid delay", n, 32'h0);
      end
    end
  endtask

  task automatic obi_access(input logic we, input logic [31:0] addr, input logic [31:0] data);
    if (!aborted) begin
      @(posedge clk);
      #1;
      obi_req   = 1'b1;
      obi_we    = we;
      obi_addr  = addr;
      obi_wdata = data;
      wait_grant(addr);
      if (!aborted) begin
        record_grant(we, addr, data);
      end
      #1;
      obi_req = 1'b0;
      wait_rvalid();
    end
  endtask

  // Writes and reads alternate with req held high the whole time
  task automatic back_to_back(input int count);
    logic        we;
    logic [31:0] addr;
    logic [31:0] data;
    if (!aborted) begin
      @(posedge clk);
      for (int i = 0; i < count && !aborted; i++) begin
        #1;
        data      = $urandom();
        we        = (i % 2 == 0);
        addr      = (i % 4 < 2) ? EXIT_VALUE : GPIO_OUT;
        obi_req   = 1'b1;
        obi_we    = we;
        obi_addr  = addr;
        obi_wdata = data;
        wait_grant(addr);
        if (!aborted) begin
          record_grant(we, addr, data);
        end
      end
      #1;
      obi_req = 1'b0;
      wait_rvalid();
    end
  endtask

  task automatic drive_fast_intr(input logic [14:0] lines);
    @(posedge clk);
    #1;
    fast_intr_in = lines;
    m_fi_pending = m_fi_pending | lines;
  endtask

  // Held for three edges so sync, GPIO_IN and status have all settled
  task automatic drive_gpio(input logic [7:0] value);
    @(posedge clk);
    #1;
    gpio_in = value;
    repeat (3) @(posedge clk);
    m_status = m_status | (value & ~m_in);
    m_in     = value;
  endtask

  task automatic read_all_regs();
    for (int i = 0; i < 10; i++) begin
      obi_access(1'b0, REG_LIST[i], 32'h0);
    end
  endtask

  // Every rvalid is matched against the oldest expectation
  always @(negedge clk) begin
    if (arst_n && obi_rvalid) begin
      rvalid_cnt++;
      if (expect_q.size() == 0) begin
        $display("The DUT returned a response that no request asked for");
        fail_cnt++;
      end else begin
        check("obi_rdata_o", obi_rdata, expect_q.pop_front());
      end
    end
  end

  initial begin
    rnd          = $urandom(43);
    arst_n       = 1'b0;
    obi_req      = 1'b0;
    obi_we       = 1'b0;
    obi_addr     = '0;
    obi_wdata    = '0;
    fast_intr_in = '0;
    gpio_in      = '0;
    rnd          = $urandom();
    boot_select  = rnd[0];
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;

    check("obi_rvalid_o", {31'b0, obi_rvalid}, 32'h0);
    check_outputs();
    read_all_regs();

    for (int i = 0; i < 4; i++) begin
      obi_access(1'b1, EXIT_VALUE, $urandom());
      obi_access(1'b0, EXIT_VALUE, 32'h0);
      obi_access(1'b1, EXIT_VALID, $urandom());
      obi_access(1'b0, EXIT_VALID, 32'h0);
      check_outputs();
    end

    obi_access(1'b1, FI_ENABLE, $urandom());
    for (int i = 0; i < 3; i++) begin
      rnd = $urandom();
      drive_fast_intr(rnd[14:0]);
      drive_fast_intr(15'h0);
      obi_access(1'b0, FI_PENDING, 32'h0);
      check_outputs();
    end
    // Clear a random mask while some lines stay high
    rnd = $urandom();
    drive_fast_intr(rnd[14:0] & m_fi_pending);
    obi_access(1'b1, FI_PENDING, $urandom());
    obi_access(1'b0, FI_PENDING, 32'h0);
    check_outputs();
    drive_fast_intr(15'h0);
    obi_access(1'b1, FI_PENDING, 32'h0000_7FFF);
    obi_access(1'b0, FI_PENDING, 32'h0);
    check_outputs();

    obi_access(1'b1, GPIO_DIR, $urandom());
    obi_access(1'b1, GPIO_OUT, $urandom());
    obi_access(1'b0, GPIO_DIR, 32'h0);
    obi_access(1'b0, GPIO_OUT, 32'h0);
    check_outputs();
    obi_access(1'b1, GPIO_INTR_EN, $urandom());
    for (int i = 0; i < 6; i++) begin
      rnd = $urandom();
      drive_gpio(rnd[7:0]);
      obi_access(1'b0, GPIO_IN, 32'h0);
      obi_access(1'b0, GPIO_INTR_STATUS, 32'h0);
      check_outputs();
      obi_access(1'b1, GPIO_INTR_STATUS, $urandom());
      obi_access(1'b0, GPIO_INTR_STATUS, 32'h0);
      check_outputs();
    end

    // Unmapped accesses must leave every register alone
    obi_access(1'b1, 32'h2000_3004, $urandom());
    obi_access(1'b1, 32'h1000_0004, $urandom());
    obi_access(1'b1, 32'h2000_F000, $urandom());
    obi_access(1'b0, 32'h2000_3004, 32'h0);
    obi_access(1'b0, 32'h3000_0008, 32'h0);
    // Flip the boot pin so BOOT_SELECT is read at both levels
    @(posedge clk);
    #1;
    boot_select = ~boot_select;
    read_all_regs();
    check_outputs();

    back_to_back(8);
    check_outputs();

    repeat (3) @(posedge clk);
    check("rvalid count", rvalid_cnt, grant_cnt);
    check("open expectations", expect_q.size(), 32'h0);

    $display("Checks: %0d, value errors: %0d, other failures: %0d",
             checks, err_cnt, fail_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: ao_peripheral_subsystem.f
ao_bus_pkg.sv
ao_map_pkg.sv
obi_to_reg.sv
ao_reg_demux.sv
soc_ctrl.sv
fast_intr_ctrl.sv
gpio_ao.sv
ao_peripheral_subsystem.sv
tb_ao_peripheral_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_ao_peripheral_subsystem
FILELIST  ?= ao_peripheral_subsystem.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

# The result is decided by the pass message in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
